/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rvvi_bridge
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_rvvi_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rvvi_bridge;
   import trace_pkg::*;
   import csr_pkg::*;

   localparam int NUM_ROWS  = 16;
   localparam int LAT_LIMIT = 8;

   // Stimulus row, record control plus CSR write plus nets
   typedef struct packed {
      logic      valid;
      xaddr_t    rd;
      logic      we;
      csr_addr_t caddr;
      xdata_t    mask;
      logic      dbg;
      irq_t      irq;
      logic      ack;
      logic      fen;
   } row_t;

   // Trace record due at the port two cycles after its row
   typedef struct packed {
      logic    valid;
      order_t  order;
      xdata_t  insn;
      logic    trap;
      logic    intr;
      mode_t   mode;
      xdata_t  pc_rdata;
      xdata_t  pc_wdata;
      xwb_t    xwb;
      xdata_t  xwdata;
      csr_wb_t csr_wb;
      xdata_t  csr_wdata;
      logic    miss;
   } exp_t;

   // DUT inputs
   logic      rvvi;
   logic      arst_n_i;
   logic      valid_i;
   order_t    order_i;
   xdata_t    insn_i;
   logic      trap_i;
   logic      intr_i;
   mode_t     mode_i;
   xdata_t    pc_rdata_i;
   xdata_t    pc_wdata_i;
   xaddr_t    rd_addr_i;
   xdata_t    rd_wdata_i;
   logic      csr_we_i;
   csr_addr_t csr_addr_i;
   xdata_t    csr_wdata_i;
   xdata_t    csr_wmask_i;
   logic      debug_req_i;
   irq_t      irq_i;
   logic      irq_ack_i;
   logic      fetch_enable_i;

   // DUT outputs
   logic      valid_o;
   order_t    order_o;
   xdata_t    insn_o;
   logic      trap_o;
   logic      intr_o;
   mode_t     mode_o;
   xdata_t    pc_rdata_o;
   xdata_t    pc_wdata_o;
   xwb_t      x_wb_o;
   xdata_t    x_wdata_o;
   csr_wb_t   csr_wb_o;
   xdata_t    csr_wdata_o;
   logic      csr_miss_o;
   logic      haltreq_o;
   logic      haltreq_chg_o;
   irq_t      irq_o;
   logic      irq_chg_o;

   // Reference model of the halt and interrupt nets
   logic      m_halt_net;
   logic      m_halt_lvl;
   logic      m_halt_prev;
   irq_t      m_irq_net;
   irq_t      m_irq_ret;
   irq_t      m_irq_ack;
   irq_t      m_irq_lvl;
   irq_t      m_irq_prev;

   row_t        rows [NUM_ROWS];
   exp_t        exp_q [NUM_ROWS+2];
   exp_t        probe_exp;
   logic [31:0] lfsr;
   int          errors;
   int          checks;
   int          lat;

   rvvi_bridge_top uut (.*);

   always #20 rvvi = ~rvvi;

   //////////////////////////////////////////////////////////////////////
   // Net model
   //////////////////////////////////////////////////////////////////////

   // Inputs change 2 ns after the edge, stable here
   always @(posedge rvvi) begin
      if (!arst_n_i) begin
         m_halt_net  <= 1'b0;
         m_halt_lvl  <= 1'b0;
         m_halt_prev <= 1'b0;
         m_irq_net   <= '0;
         m_irq_ret   <= '0;
         m_irq_ack   <= '0;
         m_irq_lvl   <= '0;
         m_irq_prev  <= '0;
      end else begin
         // Retirement resamples, otherwise a request only sets
         m_halt_net  <= valid_i ? debug_req_i : (m_halt_net | debug_req_i);
         // Live lines merged with both snapshots
         m_irq_net   <= irq_i | m_irq_ret | m_irq_ack;
         m_irq_ret   <= valid_i ? irq_i : m_irq_ret;
         m_irq_ack   <= irq_ack_i ? irq_i : (valid_i ? '0 : m_irq_ack);
         // Level one cycle behind the net
         m_halt_lvl  <= m_halt_net;
         m_halt_prev <= m_halt_lvl;
         m_irq_lvl   <= m_irq_net;
         m_irq_prev  <= m_irq_lvl;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////////////////////////

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   task automatic draw_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[62:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // Tracked slot of a CSR address, -1 when not tracked
   function automatic int slot_of(input csr_addr_t a);
      case (a)
         CSR_MSTATUS:  slot_of = 0;
         CSR_MIE:      slot_of = 1;
         CSR_MTVEC:    slot_of = 2;
         CSR_MSCRATCH: slot_of = 3;
         CSR_MEPC:     slot_of = 4;
         CSR_MCAUSE:   slot_of = 5;
         CSR_MTVAL:    slot_of = 6;
         CSR_MIP:      slot_of = 7;
         default:      slot_of = -1;
      endcase
   endfunction

   // No retirement, no nets, fetch enable left as it is
   function automatic row_t idle_row();
      row_t r;
      r     = '0;
      r.fen = fetch_enable_i;
      return r;
   endfunction

   // Drive one cycle of inputs and derive its trace record
   task automatic apply_row(input row_t r, output exp_t e);
      logic [63:0] v;
      int          slot;
      draw_bits(64, v);
      order_i = v;
      draw_bits(32, v);
      insn_i = v[31:0];
      draw_bits(1, v);
      trap_i = v[0];
      draw_bits(1, v);
      intr_i = v[0];
      draw_bits(2, v);
      mode_i = v[1:0];
      draw_bits(32, v);
      pc_rdata_i = v[31:0];
      draw_bits(32, v);
      pc_wdata_i = v[31:0];
      draw_bits(32, v);
      rd_wdata_i = v[31:0];
      draw_bits(32, v);
      csr_wdata_i    = v[31:0];
      valid_i        = r.valid;
      rd_addr_i      = r.rd;
      csr_we_i       = r.we;
      csr_addr_i     = r.caddr;
      csr_wmask_i    = r.mask;
      debug_req_i    = r.dbg;
      irq_i          = r.irq;
      irq_ack_i      = r.ack;
      fetch_enable_i = r.fen;
      slot = slot_of(r.caddr);
      e.valid     = r.valid;
      e.order     = order_i;
      e.insn      = insn_i;
      e.trap      = trap_i;
      e.intr      = intr_i;
      e.mode      = mode_i;
      e.pc_rdata  = pc_rdata_i;
      e.pc_wdata  = pc_wdata_i;
      e.xwdata    = rd_wdata_i;
      // x0 is never written
      e.xwb       = (r.valid && r.rd != '0) ? (xwb_t'(1) << r.rd) : '0;
      e.csr_wb    = (r.valid && r.we && slot >= 0 && r.mask != '0) ?
                    (csr_wb_t'(1) << slot) : '0;
      e.csr_wdata = csr_wdata_i & r.mask;
      e.miss      = r.valid && r.we && slot < 0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic check_xwb(input string name, input xwb_t exp, input xwb_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_csr_wb(input string name, input csr_wb_t exp, input csr_wb_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   task automatic check_data(input string name, input xdata_t exp, input xdata_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_order(input string name, input order_t exp, input order_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_mode(input string name, input mode_t exp, input mode_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   task automatic check_irq(input string name, input irq_t exp, input irq_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   // Payload only matters with valid, CSR data only with a slot hit
   task automatic check_record(input exp_t e);
      check_bit("valid_o", e.valid, valid_o);
      check_xwb("x_wb_o", e.xwb, x_wb_o);
      check_csr_wb("csr_wb_o", e.csr_wb, csr_wb_o);
      check_bit("csr_miss_o", e.miss, csr_miss_o);
      if (e.valid) begin
         check_order("order_o", e.order, order_o);
         check_data("insn_o", e.insn, insn_o);
         check_bit("trap_o", e.trap, trap_o);
         check_bit("intr_o", e.intr, intr_o);
         check_mode("mode_o", e.mode, mode_o);
         check_data("pc_rdata_o", e.pc_rdata, pc_rdata_o);
         check_data("pc_wdata_o", e.pc_wdata, pc_wdata_o);
         check_data("x_wdata_o", e.xwdata, x_wdata_o);
      end
      if (e.csr_wb != '0) begin
         check_data("csr_wdata_o", e.csr_wdata, csr_wdata_o);
      end
   endtask

   // Interrupt strobe is masked until fetch starts
   task automatic check_nets();
      check_bit("haltreq_o", m_halt_lvl, haltreq_o);
      check_bit("haltreq_chg_o", m_halt_lvl != m_halt_prev, haltreq_chg_o);
      check_irq("irq_o", m_irq_lvl, irq_o);
      check_bit("irq_chg_o", (m_irq_lvl != m_irq_prev) && fetch_enable_i, irq_chg_o);
   endtask

   // Idle cycles until valid_o rises, cycles is 0 on timeout
   task automatic wait_valid_o(input int limit, output int cycles);
      exp_t dummy;
      int   n;
      n      = 0;
      cycles = 0;
      while (cycles == 0 && n < limit) begin
         @(posedge rvvi);
         #2;
         apply_row(idle_row(), dummy);
         @(negedge rvvi);
         check_nets();
         n++;
         if (valid_o === 1'b1) begin
            cycles = n;
         end
      end
      if (cycles == 0) begin
         errors++;
         $display("Timeout: valid_o did not rise within %0d cycles of a retirement", limit);
      end
   endtask

   // Columns: valid rd we csr_addr mask debug_req irq irq_ack fetch_enable
   task automatic load_table();
      rows[0]  = '{1'b1, 5'd5,  1'b1, CSR_MSTATUS,  32'hffff_ffff, 1'b0, 32'h0,  1'b0, 1'b0};
      rows[1]  = '{1'b1, 5'd0,  1'b1, CSR_MIE,      32'h0000_ffff, 1'b0, 32'h0,  1'b0, 1'b0};
      rows[2]  = '{1'b1, 5'd31, 1'b1, CSR_MTVEC,    32'hffff_ffff, 1'b0, 32'h0,  1'b0, 1'b0};
      // CSR write with no retirement
      rows[3]  = '{1'b0, 5'd7,  1'b1, CSR_MSCRATCH, 32'hffff_ffff, 1'b0, 32'h0,  1'b0, 1'b0};
      rows[4]  = '{1'b1, 5'd1,  1'b1, CSR_MSCRATCH, 32'hf0f0_f0f0, 1'b0, 32'h0,  1'b0, 1'b0};
      // Halt taken at a retirement, then sticky while idle
      rows[5]  = '{1'b1, 5'd12, 1'b1, CSR_MEPC,     32'hffff_ffff, 1'b1, 32'h0,  1'b0, 1'b0};
      rows[6]  = '{1'b0, 5'd0,  1'b1, 12'h7c0,      32'hffff_ffff, 1'b0, 32'h0,  1'b0, 1'b0};
      rows[7]  = '{1'b1, 5'd9,  1'b1, CSR_MCAUSE,   32'h0000_000f, 1'b0, 32'h0,  1'b0, 1'b0};
      rows[8]  = '{1'b1, 5'd3,  1'b1, CSR_MTVAL,    32'hffff_ffff, 1'b0, 32'h0,  1'b0, 1'b0};
      rows[9]  = '{1'b1, 5'd4,  1'b1, CSR_MIP,      32'hffff_ffff, 1'b0, 32'h0,  1'b0, 1'b0};
      // Zero mask, then an untracked address
      rows[10] = '{1'b1, 5'd6,  1'b1, CSR_MIP,      32'h0,         1'b0, 32'h0,  1'b0, 1'b0};
      rows[11] = '{1'b1, 5'd8,  1'b1, 12'h7c0,      32'hffff_ffff, 1'b0, 32'h0,  1'b0, 1'b0};
      // Halt set while idle, interrupt acknowledged before fetch
      rows[12] = '{1'b0, 5'd0,  1'b0, 12'h0,        32'h0,         1'b1, 32'h10, 1'b1, 1'b0};
      rows[13] = '{1'b0, 5'd0,  1'b0, 12'h0,        32'h0,         1'b0, 32'h0,  1'b0, 1'b0};
      rows[14] = '{1'b1, 5'd2,  1'b0, 12'h0,        32'h0,         1'b0, 32'h4,  1'b0, 1'b0};
      rows[15] = '{1'b0, 5'd0,  1'b0, 12'h0,        32'h0,         1'b0, 32'h0,  1'b0, 1'b1};
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      errors         = 0;
      checks         = 0;
      lat            = 0;
      lfsr           = 32'hd20b;
      rvvi           = 1'b0;
      arst_n_i       = 1'b0;
      valid_i        = 1'b0;
      order_i        = '0;
      insn_i         = '0;
      trap_i         = 1'b0;
      intr_i         = 1'b0;
      mode_i         = '0;
      pc_rdata_i     = '0;
      pc_wdata_i     = '0;
      rd_addr_i      = '0;
      rd_wdata_i     = '0;
      csr_we_i       = 1'b0;
      csr_addr_i     = '0;
      csr_wdata_i    = '0;
      csr_wmask_i    = '0;
      debug_req_i    = 1'b0;
      irq_i          = '0;
      irq_ack_i      = 1'b0;
      fetch_enable_i = 1'b0;
      load_table();

      repeat (3) @(posedge rvvi);
      #2;
      arst_n_i = 1'b1;

      // Everything quiet out of reset
      @(negedge rvvi);
      check_bit("valid_o", 1'b0, valid_o);
      check_xwb("x_wb_o", '0, x_wb_o);
      check_csr_wb("csr_wb_o", '0, csr_wb_o);
      check_bit("csr_miss_o", 1'b0, csr_miss_o);
      check_bit("haltreq_o", 1'b0, haltreq_o);
      check_bit("haltreq_chg_o", 1'b0, haltreq_chg_o);
      check_irq("irq_o", '0, irq_o);
      check_bit("irq_chg_o", 1'b0, irq_chg_o);

      // Single retirement, measure its latency
      @(posedge rvvi);
      #2;
      apply_row('{1'b1, 5'd10, 1'b0, 12'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0}, probe_exp);
      wait_valid_o(LAT_LIMIT, lat);
      if (lat == 2) begin
         check_record(probe_exp);
      end else if (lat != 0) begin
         errors++;
         $display("Latency from valid_i to valid_o was %0d cycles instead of 2", lat);
      end

      // Table rows, then two idle cycles to drain the pipe
      for (int j = 0; j < NUM_ROWS + 2; j++) begin
         @(posedge rvvi);
         #2;
         if (j < NUM_ROWS) begin
            apply_row(rows[j], exp_q[j]);
         end else begin
            apply_row(idle_row(), exp_q[j]);
         end
         @(negedge rvvi);
         check_nets();
         if (j >= 2) begin
            check_record(exp_q[j-2]);
         end
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/csr_capture.sv */
`timescale 1ns/10ps
`default_nettype none

// CSR write lookup against the tracked slot table
module csr_capture (
   input  logic                rvvi,
   input  logic                arst_n_i,
   input  logic                csr_we_i,
   input  csr_pkg::csr_addr_t  csr_addr_i,
   input  trace_pkg::xdata_t   csr_wdata_i,
   input  trace_pkg::xdata_t   csr_wmask_i,
   output csr_pkg::csr_wb_t    csr_wb_o,
   output trace_pkg::xdata_t   csr_wdata_o,
   output logic                csr_miss_o
);
   import csr_pkg::*;

   logic      hit;
   csr_slot_t slot_idx;
   csr_wb_t   csr_wb_d;

   //////////////////////////////////////////////////////////////////////
   // Address match
   //////////////////////////////////////////////////////////////////////

   // Table entries are distinct, at most one matches
   always_comb begin
      hit      = 1'b0;
      slot_idx = '0;
      for (int i = 0; i < NUM_CSR_SLOT; i++) begin
         if (csr_addr_i == CSR_SLOT_ADDR[i]) begin
            hit      = 1'b1;
            slot_idx = csr_slot_t'(i);
         end
      end
   end

   // Zero mask means the CSR was read only
   assign csr_wb_d = (csr_we_i && hit && (|csr_wmask_i)) ? (csr_wb_t'(1) << slot_idx) : '0;

   // Slot vector and miss strobe
   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         csr_wb_o   <= '0;
         csr_miss_o <= 1'b0;
      end else begin
         csr_wb_o   <= csr_wb_d;
         csr_miss_o <= csr_we_i && !hit;
      end
   end

   // Only bits under the mask reach the trace
   always_ff @(posedge rvvi) begin
      csr_wdata_o <= csr_wdata_i & csr_wmask_i;
   end

endmodule

`default_nettype wire

/* hdl/csr_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Tracked machine CSRs
//////////////////////////////////////////////////////////////////////

package csr_pkg;

   // Standard CSR address space
   localparam int CSR_ADDR_W = 12;

   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   // Slots on the trace port, one per tracked CSR
   localparam int NUM_CSR_SLOT = 8;

   typedef logic [NUM_CSR_SLOT-1:0] csr_wb_t;

   // Index of a slot in the table below
   typedef logic [$clog2(NUM_CSR_SLOT)-1:0] csr_slot_t;

   // Machine trap setup and handling
   localparam csr_addr_t CSR_MSTATUS  = 12'h300;
   localparam csr_addr_t CSR_MIE      = 12'h304;
   localparam csr_addr_t CSR_MTVEC    = 12'h305;
   localparam csr_addr_t CSR_MSCRATCH = 12'h340;
   localparam csr_addr_t CSR_MEPC     = 12'h341;
   localparam csr_addr_t CSR_MCAUSE   = 12'h342;
   localparam csr_addr_t CSR_MTVAL    = 12'h343;
   localparam csr_addr_t CSR_MIP      = 12'h344;

   // Slot order, entry n drives bit n of csr_wb_t
   localparam csr_addr_t CSR_SLOT_ADDR [NUM_CSR_SLOT] = '{
      CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
      CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP
   };

endpackage

`default_nettype wire

/* hdl/net_change.sv */
`timescale 1ns/10ps
`default_nettype none

// Level register with a change strobe, for any packed net
module net_change #(
   parameter type net_t = logic
) (
   input  logic rvvi,
   input  logic arst_n_i,
   input  net_t net_i,
   output net_t level_o,
   output logic chg_o
);

   // Level one cycle back
   net_t level_prev;

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         level_o    <= '0;
         level_prev <= '0;
      end else begin
         level_o    <= net_i;
         level_prev <= level_o;
      end
   end

   // High in the cycle the new level first shows
   assign chg_o = (level_o != level_prev);

endmodule

`default_nettype wire

/* hdl/net_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

// Halt request and interrupt nets for the reference port
module net_tracker (
   input  logic             rvvi,
   input  logic             arst_n_i,
   input  logic             valid_i,
   input  logic             debug_req_i,
   input  trace_pkg::irq_t  irq_i,
   input  logic             irq_ack_i,
   input  logic             fetch_enable_i,
   output logic             haltreq_o,
   output logic             haltreq_chg_o,
   output trace_pkg::irq_t  irq_o,
   output logic             irq_chg_o
);
   import trace_pkg::*;

   logic halt_net;
   irq_t irq_valid;
   irq_t irq_ack;
   irq_t irq_net;
   logic irq_chg;

   //////////////////////////////////////////////////////////////////////
   // Net state
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         halt_net  <= 1'b0;
         irq_valid <= '0;
         irq_ack   <= '0;
         irq_net   <= '0;
      end else begin
         // Sticky on request, resampled at each retirement
         if (valid_i) begin
            halt_net <= debug_req_i;
         end else if (debug_req_i) begin
            halt_net <= 1'b1;
         end
         // Retirement snapshot, also drops the ack copy
         if (valid_i) begin
            irq_valid <= irq_i;
            irq_ack   <= '0;
         end
         // Ack snapshot wins over the clear
         if (irq_ack_i) begin
            irq_ack <= irq_i;
         end
         irq_net <= irq_i | irq_valid | irq_ack;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Levels and change strobes
   //////////////////////////////////////////////////////////////////////

   net_change #(.net_t(logic)) u_halt_chg (
      .rvvi     (rvvi),
      .arst_n_i (arst_n_i),
      .net_i    (halt_net),
      .level_o  (haltreq_o),
      .chg_o    (haltreq_chg_o)
   );

   net_change #(.net_t(irq_t)) u_irq_chg (
      .rvvi     (rvvi),
      .arst_n_i (arst_n_i),
      .net_i    (irq_net),
      .level_o  (irq_o),
      .chg_o    (irq_chg)
   );

   // Core not started yet, no interrupt events
   assign irq_chg_o = irq_chg && fetch_enable_i;

endmodule

`default_nettype wire

/* hdl/retire_decode.sv */
`timescale 1ns/10ps
`default_nettype none

// First pipeline stage for the retirement record
module retire_decode (
   input  logic               rvvi,
   input  logic               arst_n_i,
   input  logic               valid_i,
   input  trace_pkg::order_t  order_i,
   input  trace_pkg::xdata_t  insn_i,
   input  logic               trap_i,
   input  logic               intr_i,
   input  trace_pkg::mode_t   mode_i,
   input  trace_pkg::xdata_t  pc_rdata_i,
   input  trace_pkg::xdata_t  pc_wdata_i,
   input  trace_pkg::xaddr_t  rd_addr_i,
   input  trace_pkg::xdata_t  rd_wdata_i,
   output logic               valid_o,
   output trace_pkg::order_t  order_o,
   output trace_pkg::xdata_t  insn_o,
   output logic               trap_o,
   output logic               intr_o,
   output trace_pkg::mode_t   mode_o,
   output trace_pkg::xdata_t  pc_rdata_o,
   output trace_pkg::xdata_t  pc_wdata_o,
   output trace_pkg::xaddr_t  rd_addr_o,
   output trace_pkg::xdata_t  rd_wdata_o,
   output trace_pkg::xwb_t    x_wb_o
);
   import trace_pkg::*;

   // One-hot write-back before the register
   xwb_t x_wb_d;

   // x0 never takes a write, idle records carry none
   always_comb begin
      x_wb_d = '0;
      if (valid_i && (rd_addr_i != '0)) begin
         x_wb_d[rd_addr_i] = 1'b1;
      end
   end

   // Control bits
   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_o <= 1'b0;
         x_wb_o  <= '0;
      end else begin
         valid_o <= valid_i;
         x_wb_o  <= x_wb_d;
      end
   end

   // Record payload, qualified downstream by valid
   always_ff @(posedge rvvi) begin
      order_o    <= order_i;
      insn_o     <= insn_i;
      trap_o     <= trap_i;
      intr_o     <= intr_i;
      mode_o     <= mode_i;
      pc_rdata_o <= pc_rdata_i;
      pc_wdata_o <= pc_wdata_i;
      rd_addr_o  <= rd_addr_i;
      rd_wdata_o <= rd_wdata_i;
   end

endmodule

`default_nettype wire

/* hdl/rvvi_bridge_top.sv */
`timescale 1ns/10ps
`default_nettype none

// Retirement trace bridge, two cycles from record to trace port
module rvvi_bridge_top (
   input  logic                rvvi,
   input  logic                arst_n_i,
   // Retirement record
   input  logic                valid_i,
   input  trace_pkg::order_t   order_i,
   input  trace_pkg::xdata_t   insn_i,
   input  logic                trap_i,
   input  logic                intr_i,
   input  trace_pkg::mode_t    mode_i,
   input  trace_pkg::xdata_t   pc_rdata_i,
   input  trace_pkg::xdata_t   pc_wdata_i,
   input  trace_pkg::xaddr_t   rd_addr_i,
   input  trace_pkg::xdata_t   rd_wdata_i,
   // CSR write
   input  logic                csr_we_i,
   input  csr_pkg::csr_addr_t  csr_addr_i,
   input  trace_pkg::xdata_t   csr_wdata_i,
   input  trace_pkg::xdata_t   csr_wmask_i,
   // External nets
   input  logic                debug_req_i,
   input  trace_pkg::irq_t     irq_i,
   input  logic                irq_ack_i,
   input  logic                fetch_enable_i,
   // Trace record
   output logic                valid_o,
   output trace_pkg::order_t   order_o,
   output trace_pkg::xdata_t   insn_o,
   output logic                trap_o,
   output logic                intr_o,
   output trace_pkg::mode_t    mode_o,
   output trace_pkg::xdata_t   pc_rdata_o,
   output trace_pkg::xdata_t   pc_wdata_o,
   output trace_pkg::xwb_t     x_wb_o,
   output trace_pkg::xdata_t   x_wdata_o,
   output csr_pkg::csr_wb_t    csr_wb_o,
   output trace_pkg::xdata_t   csr_wdata_o,
   output logic                csr_miss_o,
   // Net levels and change strobes
   output logic                haltreq_o,
   output logic                haltreq_chg_o,
   output trace_pkg::irq_t     irq_o,
   output logic                irq_chg_o
);
   import trace_pkg::*;
   import csr_pkg::*;

   // Decode stage
   logic    dec_valid;
   order_t  dec_order;
   xdata_t  dec_insn;
   logic    dec_trap;
   logic    dec_intr;
   mode_t   dec_mode;
   xdata_t  dec_pc_rdata;
   xdata_t  dec_pc_wdata;
   xdata_t  dec_rd_wdata;
   xwb_t    dec_x_wb;

   // Capture stage
   csr_wb_t cap_csr_wb;
   xdata_t  cap_csr_wdata;
   logic    cap_csr_miss;

   //////////////////////////////////////////////////////////////////////
   // Stage 1
   //////////////////////////////////////////////////////////////////////

   // Register address travels as the one-hot vector
   retire_decode u_decode (
      .rvvi       (rvvi),
      .arst_n_i   (arst_n_i),
      .valid_i    (valid_i),
      .order_i    (order_i),
      .insn_i     (insn_i),
      .trap_i     (trap_i),
      .intr_i     (intr_i),
      .mode_i     (mode_i),
      .pc_rdata_i (pc_rdata_i),
      .pc_wdata_i (pc_wdata_i),
      .rd_addr_i  (rd_addr_i),
      .rd_wdata_i (rd_wdata_i),
      .valid_o    (dec_valid),
      .order_o    (dec_order),
      .insn_o     (dec_insn),
      .trap_o     (dec_trap),
      .intr_o     (dec_intr),
      .mode_o     (dec_mode),
      .pc_rdata_o (dec_pc_rdata),
      .pc_wdata_o (dec_pc_wdata),
      .rd_addr_o  (),
      .rd_wdata_o (dec_rd_wdata),
      .x_wb_o     (dec_x_wb)
   );

   csr_capture u_capture (
      .rvvi        (rvvi),
      .arst_n_i    (arst_n_i),
      .csr_we_i    (csr_we_i),
      .csr_addr_i  (csr_addr_i),
      .csr_wdata_i (csr_wdata_i),
      .csr_wmask_i (csr_wmask_i),
      .csr_wb_o    (cap_csr_wb),
      .csr_wdata_o (cap_csr_wdata),
      .csr_miss_o  (cap_csr_miss)
   );

   // Nets run off raw inputs, outside the record pipe
   net_tracker u_nets (
      .rvvi           (rvvi),
      .arst_n_i       (arst_n_i),
      .valid_i        (valid_i),
      .debug_req_i    (debug_req_i),
      .irq_i          (irq_i),
      .irq_ack_i      (irq_ack_i),
      .fetch_enable_i (fetch_enable_i),
      .haltreq_o      (haltreq_o),
      .haltreq_chg_o  (haltreq_chg_o),
      .irq_o          (irq_o),
      .irq_chg_o      (irq_chg_o)
   );

   //////////////////////////////////////////////////////////////////////
   // Stage 2
   //////////////////////////////////////////////////////////////////////

   trace_result u_result (
      .rvvi        (rvvi),
      .arst_n_i    (arst_n_i),
      .valid_i     (dec_valid),
      .order_i     (dec_order),
      .insn_i      (dec_insn),
      .trap_i      (dec_trap),
      .intr_i      (dec_intr),
      .mode_i      (dec_mode),
      .pc_rdata_i  (dec_pc_rdata),
      .pc_wdata_i  (dec_pc_wdata),
      .x_wb_i      (dec_x_wb),
      .x_wdata_i   (dec_rd_wdata),
      .csr_wb_i    (cap_csr_wb),
      .csr_wdata_i (cap_csr_wdata),
      .csr_miss_i  (cap_csr_miss),
      .valid_o     (valid_o),
      .order_o     (order_o),
      .insn_o      (insn_o),
      .trap_o      (trap_o),
      .intr_o      (intr_o),
      .mode_o      (mode_o),
      .pc_rdata_o  (pc_rdata_o),
      .pc_wdata_o  (pc_wdata_o),
      .x_wb_o      (x_wb_o),
      .x_wdata_o   (x_wdata_o),
      .csr_wb_o    (csr_wb_o),
      .csr_wdata_o (csr_wdata_o),
      .csr_miss_o  (csr_miss_o)
   );

endmodule

`default_nettype wire

/* hdl/trace_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Retirement record and trace output types
//////////////////////////////////////////////////////////////////////

package trace_pkg;

   // Integer datapath width
   localparam int XLEN = 32;

   // Architectural integer registers, x0 included
   localparam int NUM_XREG = 32;

   // Retirement counter and privilege fields
   localparam int ORDER_W = 64;
   localparam int MODE_W  = 2;

   // Interrupt lines seen by the core
   localparam int IRQ_W = 32;

   // Register value, PC or instruction word
   typedef logic [XLEN-1:0] xdata_t;

   // Register address, wide enough for NUM_XREG
   typedef logic [$clog2(NUM_XREG)-1:0] xaddr_t;

   // One bit per integer register
   typedef logic [NUM_XREG-1:0] xwb_t;

   typedef logic [ORDER_W-1:0] order_t;

   // M/S/U encoding as reported by the core
   typedef logic [MODE_W-1:0] mode_t;

   // Interrupt vector, bit n is line n
   typedef logic [IRQ_W-1:0] irq_t;

endpackage

`default_nettype wire

/* hdl/trace_result.sv */
`timescale 1ns/10ps
`default_nettype none

// Output register stage of the trace record
module trace_result (
   input  logic                rvvi,
   input  logic                arst_n_i,
   input  logic                valid_i,
   input  trace_pkg::order_t   order_i,
   input  trace_pkg::xdata_t   insn_i,
   input  logic                trap_i,
   input  logic                intr_i,
   input  trace_pkg::mode_t    mode_i,
   input  trace_pkg::xdata_t   pc_rdata_i,
   input  trace_pkg::xdata_t   pc_wdata_i,
   input  trace_pkg::xwb_t     x_wb_i,
   input  trace_pkg::xdata_t   x_wdata_i,
   input  csr_pkg::csr_wb_t    csr_wb_i,
   input  trace_pkg::xdata_t   csr_wdata_i,
   input  logic                csr_miss_i,
   output logic                valid_o,
   output trace_pkg::order_t   order_o,
   output trace_pkg::xdata_t   insn_o,
   output logic                trap_o,
   output logic                intr_o,
   output trace_pkg::mode_t    mode_o,
   output trace_pkg::xdata_t   pc_rdata_o,
   output trace_pkg::xdata_t   pc_wdata_o,
   output trace_pkg::xwb_t     x_wb_o,
   output trace_pkg::xdata_t   x_wdata_o,
   output csr_pkg::csr_wb_t    csr_wb_o,
   output trace_pkg::xdata_t   csr_wdata_o,
   output logic                csr_miss_o
);

   //////////////////////////////////////////////////////////////////////
   // Write-back strobes
   //////////////////////////////////////////////////////////////////////

   // CSR inputs may toggle with no retirement, drop them here
   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_o    <= 1'b0;
         x_wb_o     <= '0;
         csr_wb_o   <= '0;
         csr_miss_o <= 1'b0;
      end else begin
         valid_o    <= valid_i;
         x_wb_o     <= valid_i ? x_wb_i : '0;
         csr_wb_o   <= valid_i ? csr_wb_i : '0;
         csr_miss_o <= valid_i && csr_miss_i;
      end
   end

   // Record fields, only meaningful with valid_o
   always_ff @(posedge rvvi) begin
      order_o     <= order_i;
      insn_o      <= insn_i;
      trap_o      <= trap_i;
      intr_o      <= intr_i;
      mode_o      <= mode_i;
      pc_rdata_o  <= pc_rdata_i;
      pc_wdata_o  <= pc_wdata_i;
      x_wdata_o   <= x_wdata_i;
      csr_wdata_o <= csr_wdata_i;
   end

endmodule

`default_nettype wire

/* vlog.f */
hdl/trace_pkg.sv
hdl/csr_pkg.sv
hdl/retire_decode.sv
hdl/csr_capture.sv
hdl/net_change.sv
hdl/net_tracker.sv
hdl/trace_result.sv
hdl/rvvi_bridge_top.sv
bench/tb_rvvi_bridge.sv
